//--- src/rs_pkg.sv
package rs_pkg;

    // ========================================
    // sizing
    // ========================================
    localparam int RS_DEPTH       = 8;
    localparam int DISPATCH_WIDTH = 2;
    localparam int CDB_WIDTH      = 2;
    localparam int PHYS_REGS      = 32;
    localparam int FU_NUM         = 3;
    localparam int TAG_W          = $clog2(PHYS_REGS);
    localparam int ROB_W          = 4;
    // free slot count saturates at DISPATCH_WIDTH
    localparam int COUNT_W        = 2;

    // ========================================
    // encodings
    // ========================================
    typedef enum logic [1:0] {
        FU_ALU    = 2'd0,
        FU_MULT   = 2'd1,
        FU_BRANCH = 2'd2
    } fu_type_e;

    // selects which view of inst_u carries the immediate
    typedef enum logic {
        IMM_I = 1'b0,
        IMM_U = 1'b1
    } imm_kind_e;

    // one instruction word, two immediate layouts
    typedef union packed {
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
    } inst_u;

    // ========================================
    // packets
    // ========================================
    typedef struct packed {
        fu_type_e          fu_type;
        logic [3:0]        alu_func;
        imm_kind_e         imm_kind;
        inst_u             inst;
        logic [ROB_W-1:0]  rob_idx;
        logic [TAG_W-1:0]  dest_tag;
        logic [TAG_W-1:0]  src1_tag;
        logic              src1_ready;
        logic [TAG_W-1:0]  src2_tag;
        logic              src2_ready;
        logic              valid;
    } disp_pkt_t;

    // slot contents, spec marks work behind the open branch
    typedef struct packed {
        disp_pkt_t pkt;
        logic      spec;
    } rs_entry_t;

    typedef struct packed {
        logic              valid;
        fu_type_e          fu_type;
        logic [3:0]        alu_func;
        logic [ROB_W-1:0]  rob_idx;
        logic [TAG_W-1:0]  dest_tag;
        logic [TAG_W-1:0]  src1_tag;
        logic [TAG_W-1:0]  src2_tag;
        logic [31:0]       imm;
    } issue_pkt_t;

endpackage

//--- src/rs_entry.sv
`timescale 1ns/1ps

module rs_entry import rs_pkg::*; (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            flush_i,
    input  logic                            load_i,
    input  disp_pkt_t                       pkt_i,
    input  logic                            spec_i,
    input  logic                            issue_i,
    input  logic                            squash_i,
    input  logic                            clear_spec_i,
    input  logic [CDB_WIDTH-1:0]            cdb_valid_i,
    input  logic [CDB_WIDTH-1:0][TAG_W-1:0] cdb_tag_i,
    output rs_entry_t                       entry_o,
    output logic                            empty_o,
    output logic                            ready_o
);

    // control state
    logic valid_q;
    logic spec_q;
    logic src1_rdy_q;
    logic src2_rdy_q;
    // payload
    disp_pkt_t pkt_q;

    // any broadcast lane carrying this tag
    function automatic logic tag_hit(input logic [TAG_W-1:0] tag,
                                     input logic [CDB_WIDTH-1:0] valid,
                                     input logic [CDB_WIDTH-1:0][TAG_W-1:0] bus);
        logic hit;
        hit = 1'b0;
        for (int l = 0; l < CDB_WIDTH; l++) begin
            if (valid[l] && bus[l] == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // ========================================
    // occupancy, speculation, wakeup
    // ========================================
    always_ff @(posedge clock) begin
        if (reset || flush_i) begin
            valid_q    <= 1'b0;
            spec_q     <= 1'b0;
            src1_rdy_q <= 1'b0;
            src2_rdy_q <= 1'b0;
        end else if (load_i) begin
            valid_q    <= 1'b1;
            spec_q     <= spec_i;
            // same-cycle broadcast counts for the incoming packet
            src1_rdy_q <= pkt_i.src1_ready | tag_hit(pkt_i.src1_tag, cdb_valid_i, cdb_tag_i);
            src2_rdy_q <= pkt_i.src2_ready | tag_hit(pkt_i.src2_tag, cdb_valid_i, cdb_tag_i);
        end else begin
            src1_rdy_q <= src1_rdy_q | tag_hit(pkt_q.src1_tag, cdb_valid_i, cdb_tag_i);
            src2_rdy_q <= src2_rdy_q | tag_hit(pkt_q.src2_tag, cdb_valid_i, cdb_tag_i);
            if (issue_i || (squash_i && spec_q)) begin
                valid_q <= 1'b0;
                spec_q  <= 1'b0;
            end else if (clear_spec_i) begin
                spec_q  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (load_i) begin
            pkt_q <= pkt_i;
        end
    end

    // live view, status bits taken from control state
    always_comb begin
        entry_o                = '{pkt: pkt_q, spec: spec_q};
        entry_o.pkt.valid      = valid_q;
        entry_o.pkt.src1_ready = src1_rdy_q;
        entry_o.pkt.src2_ready = src2_rdy_q;
    end

    assign empty_o = ~valid_q;
    assign ready_o = valid_q & src1_rdy_q & src2_rdy_q;

endmodule

//--- src/dispatch_select.sv
`timescale 1ns/1ps

module dispatch_select import rs_pkg::*; (
    input  logic [RS_DEPTH-1:0]                     empty_i,
    input  logic [DISPATCH_WIDTH-1:0]               disp_valid_i,
    output logic [DISPATCH_WIDTH-1:0][RS_DEPTH-1:0] grant_o
);

    // ========================================
    // lowest free slot per lane, in lane order
    // ========================================
    always_comb begin
        logic [RS_DEPTH-1:0] avail;
        logic                found;
        avail   = empty_i;
        grant_o = '0;
        for (int l = 0; l < DISPATCH_WIDTH; l++) begin
            found = 1'b0;
            // idle lane takes nothing and leaves slots to later lanes
            if (disp_valid_i[l]) begin
                for (int s = 0; s < RS_DEPTH; s++) begin
                    if (!found && avail[s]) begin
                        grant_o[l][s] = 1'b1;
                        avail[s]      = 1'b0;
                        found         = 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- src/reservation_station.sv
`timescale 1ns/1ps

module reservation_station import rs_pkg::*; (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                flush_i,
    input  logic [DISPATCH_WIDTH-1:0]           disp_valid_i,
    input  disp_pkt_t [DISPATCH_WIDTH-1:0]      disp_pkt_i,
    input  logic [CDB_WIDTH-1:0]                cdb_valid_i,
    input  logic [CDB_WIDTH-1:0][TAG_W-1:0]     cdb_tag_i,
    input  logic                                br_mispredict_i,
    input  logic                                br_correct_i,
    input  logic [RS_DEPTH-1:0]                 issue_grant_i,
    output rs_entry_t [RS_DEPTH-1:0]            entries_o,
    output logic [RS_DEPTH-1:0]                 ready_o,
    output logic [COUNT_W-1:0]                  free_slots_o,
    output logic                                rs_full_o
);

    logic [RS_DEPTH-1:0]                     slot_empty;
    logic [DISPATCH_WIDTH-1:0][RS_DEPTH-1:0] lane_grant;
    logic [DISPATCH_WIDTH-1:0]               lane_go;
    logic [DISPATCH_WIDTH-1:0]               lane_spec;
    logic [RS_DEPTH-1:0]                     slot_load;
    logic [RS_DEPTH-1:0]                     slot_spec;
    disp_pkt_t [RS_DEPTH-1:0]                slot_pkt;
    logic                                    br_open_q;
    logic                                    br_open_d;

    dispatch_select u_dispatch_select (
        .empty_i      (slot_empty),
        .disp_valid_i (disp_valid_i),
        .grant_o      (lane_grant)
    );

    // ========================================
    // branch tag tracker
    // ========================================
    always_comb begin
        logic br_seen;
        br_seen   = 1'b0;
        // nothing enters during a mispredict or flush
        lane_go   = disp_valid_i & {DISPATCH_WIDTH{~br_mispredict_i & ~flush_i}};
        for (int l = 0; l < DISPATCH_WIDTH; l++) begin
            // older lanes first, so only an earlier branch tags this lane
            lane_spec[l] = (br_open_q & ~br_correct_i) | br_seen;
            if (lane_go[l] && disp_pkt_i[l].fu_type == FU_BRANCH) begin
                br_seen = 1'b1;
            end
        end
        if (flush_i) begin
            br_open_d = 1'b0;
        end else if (br_seen) begin
            br_open_d = 1'b1;
        end else if (br_correct_i || br_mispredict_i) begin
            br_open_d = 1'b0;
        end else begin
            br_open_d = br_open_q;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            br_open_q <= 1'b0;
        end else begin
            br_open_q <= br_open_d;
        end
    end

    // ========================================
    // steering lanes into granted slots
    // ========================================
    always_comb begin
        slot_load = '0;
        slot_spec = '0;
        slot_pkt  = '0;
        for (int l = 0; l < DISPATCH_WIDTH; l++) begin
            for (int s = 0; s < RS_DEPTH; s++) begin
                if (lane_go[l] && lane_grant[l][s]) begin
                    slot_load[s] = 1'b1;
                    slot_spec[s] = lane_spec[l];
                    slot_pkt[s]  = disp_pkt_i[l];
                end
            end
        end
    end

    for (genvar s = 0; s < RS_DEPTH; s++) begin : g_slot
        rs_entry u_entry (
            .clock        (clock),
            .reset        (reset),
            .flush_i      (flush_i),
            .load_i       (slot_load[s]),
            .pkt_i        (slot_pkt[s]),
            .spec_i       (slot_spec[s]),
            .issue_i      (issue_grant_i[s]),
            .squash_i     (br_mispredict_i),
            .clear_spec_i (br_correct_i),
            .cdb_valid_i  (cdb_valid_i),
            .cdb_tag_i    (cdb_tag_i),
            .entry_o      (entries_o[s]),
            .empty_o      (slot_empty[s]),
            .ready_o      (ready_o[s])
        );
    end

    // ========================================
    // free slot count
    // ========================================
    always_comb begin
        logic [COUNT_W-1:0] cnt;
        cnt = '0;
        for (int s = 0; s < RS_DEPTH; s++) begin
            // saturate, dispatch never needs more than a full lane set
            if (slot_empty[s] && cnt < COUNT_W'(DISPATCH_WIDTH)) begin
                cnt = cnt + 1'b1;
            end
        end
        free_slots_o = cnt;
    end

    assign rs_full_o = ~|slot_empty;

endmodule

//--- src/issue_select.sv
`timescale 1ns/1ps

module issue_select import rs_pkg::*; (
    input  rs_entry_t [RS_DEPTH-1:0]  entries_i,
    input  logic [RS_DEPTH-1:0]       ready_i,
    output logic [RS_DEPTH-1:0]       issue_grant_o,
    output issue_pkt_t [FU_NUM-1:0]   issue_o
);

    // operand b from the immediate view picked at decode
    function automatic logic [31:0] decode_imm(input inst_u inst, input imm_kind_e kind);
        logic [31:0] val;
        if (kind == IMM_U) begin
            val = {inst.u.imm, 12'b0};
        end else begin
            val = {{20{inst.i.imm[11]}}, inst.i.imm};
        end
        return val;
    endfunction

    // ========================================
    // per unit type, lowest ready slot wins
    // ========================================
    always_comb begin
        logic found;
        issue_grant_o = '0;
        issue_o       = '0;
        for (int f = 0; f < FU_NUM; f++) begin
            found = 1'b0;
            for (int s = 0; s < RS_DEPTH; s++) begin
                if (!found && ready_i[s] && entries_i[s].pkt.fu_type == fu_type_e'(f)) begin
                    found                = 1'b1;
                    issue_grant_o[s]     = 1'b1;
                    issue_o[f].valid     = 1'b1;
                    issue_o[f].fu_type   = entries_i[s].pkt.fu_type;
                    issue_o[f].alu_func  = entries_i[s].pkt.alu_func;
                    issue_o[f].rob_idx   = entries_i[s].pkt.rob_idx;
                    issue_o[f].dest_tag  = entries_i[s].pkt.dest_tag;
                    issue_o[f].src1_tag  = entries_i[s].pkt.src1_tag;
                    issue_o[f].src2_tag  = entries_i[s].pkt.src2_tag;
                    issue_o[f].imm       = decode_imm(entries_i[s].pkt.inst,
                                                      entries_i[s].pkt.imm_kind);
                end
            end
        end
    end

endmodule

//--- src/rs_cluster.sv
`timescale 1ns/1ps

module rs_cluster import rs_pkg::*; (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            flush_i,
    input  logic [DISPATCH_WIDTH-1:0]       disp_valid_i,
    input  disp_pkt_t [DISPATCH_WIDTH-1:0]  disp_pkt_i,
    output logic [COUNT_W-1:0]              free_slots_o,
    output logic                            rs_full_o,
    input  logic [CDB_WIDTH-1:0]            cdb_valid_i,
    input  logic [CDB_WIDTH-1:0][TAG_W-1:0] cdb_tag_i,
    input  logic                            br_mispredict_i,
    input  logic                            br_correct_i,
    output issue_pkt_t [FU_NUM-1:0]         issue_o
);

    // station to selector and back
    rs_entry_t [RS_DEPTH-1:0] entries;
    logic [RS_DEPTH-1:0]      ready;
    logic [RS_DEPTH-1:0]      issue_grant;

    reservation_station u_station (
        .clock           (clock),
        .reset           (reset),
        .flush_i         (flush_i),
        .disp_valid_i    (disp_valid_i),
        .disp_pkt_i      (disp_pkt_i),
        .cdb_valid_i     (cdb_valid_i),
        .cdb_tag_i       (cdb_tag_i),
        .br_mispredict_i (br_mispredict_i),
        .br_correct_i    (br_correct_i),
        .issue_grant_i   (issue_grant),
        .entries_o       (entries),
        .ready_o         (ready),
        .free_slots_o    (free_slots_o),
        .rs_full_o       (rs_full_o)
    );

    issue_select u_issue_select (
        .entries_i     (entries),
        .ready_i       (ready),
        .issue_grant_o (issue_grant),
        .issue_o       (issue_o)
    );

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clock,
    output logic reset
);

    // 100 ns period
    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // reset over 8 rising edges, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

//--- tests/rs_assert.sv
`timescale 1ns/1ps

module rs_assert import rs_pkg::*; (
    input  logic                     clock,
    input  logic                     reset,
    input  logic [RS_DEPTH-1:0]      issue_grant_i,
    input  rs_entry_t [RS_DEPTH-1:0] entries_i,
    input  logic [COUNT_W-1:0]       free_slots_i
);

    // grants split by the unit type of the granted slot
    logic [FU_NUM-1:0][RS_DEPTH-1:0] grant_by_fu;
    logic [RS_DEPTH-1:0]             slot_valid;

    always_comb begin
        for (int s = 0; s < RS_DEPTH; s++) begin
            slot_valid[s] = entries_i[s].pkt.valid;
            for (int f = 0; f < FU_NUM; f++) begin
                grant_by_fu[f][s] = issue_grant_i[s] &&
                                    entries_i[s].pkt.fu_type == fu_type_e'(f);
            end
        end
    end

    // ========================================
    // grant and count properties
    // ========================================
    for (genvar f = 0; f < FU_NUM; f++) begin : g_fu
        a_grant_onehot: assert property (@(posedge clock) disable iff (reset)
            $onehot0(grant_by_fu[f]))
            else $error("more than one slot granted for unit type %0d", f);
    end

    a_grant_valid: assert property (@(posedge clock) disable iff (reset)
        (issue_grant_i & ~slot_valid) == '0)
        else $error("issue grant given to an empty slot");

    a_free_bound: assert property (@(posedge clock) disable iff (reset)
        free_slots_i <= COUNT_W'(DISPATCH_WIDTH))
        else $error("free slot count above dispatch width");

endmodule

//--- tests/rs_tb.sv
`timescale 1ns/1ps

module rs_tb import rs_pkg::*; ();

    // stimulus of one cycle plus the outputs expected after its edge
    typedef struct packed {
        logic [DISPATCH_WIDTH-1:0]       disp_valid;
        disp_pkt_t [DISPATCH_WIDTH-1:0]  disp_pkt;
        logic [CDB_WIDTH-1:0]            cdb_valid;
        logic [CDB_WIDTH-1:0][TAG_W-1:0] cdb_tag;
        logic                            flush;
        logic                            mispredict;
        logic                            correct;
        logic [COUNT_W-1:0]              free_slots;
        logic                            full;
        issue_pkt_t [FU_NUM-1:0]         issue;
    } step_t;

    logic clock;
    logic reset;
    // dut inputs
    logic                            flush;
    logic [DISPATCH_WIDTH-1:0]       disp_valid;
    disp_pkt_t [DISPATCH_WIDTH-1:0]  disp_pkt;
    logic [CDB_WIDTH-1:0]            cdb_valid;
    logic [CDB_WIDTH-1:0][TAG_W-1:0] cdb_tag;
    logic                            br_mispredict;
    logic                            br_correct;
    // dut outputs
    logic [COUNT_W-1:0]              free_slots;
    logic                            rs_full;
    issue_pkt_t [FU_NUM-1:0]         issue;

    step_t steps[$];
    int    cycle_count = 0;
    int    cycle_limit = 0;

    tb_clock u_clock (
        .clock (clock),
        .reset (reset)
    );

    rs_cluster u_dut (
        .clock           (clock),
        .reset           (reset),
        .flush_i         (flush),
        .disp_valid_i    (disp_valid),
        .disp_pkt_i      (disp_pkt),
        .free_slots_o    (free_slots),
        .rs_full_o       (rs_full),
        .cdb_valid_i     (cdb_valid),
        .cdb_tag_i       (cdb_tag),
        .br_mispredict_i (br_mispredict),
        .br_correct_i    (br_correct),
        .issue_o         (issue)
    );

    bind reservation_station rs_assert u_rs_assert (
        .clock         (clock),
        .reset         (reset),
        .issue_grant_i (issue_grant_i),
        .entries_i     (entries_o),
        .free_slots_i  (free_slots_o)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    // ========================================
    // golden file parsing
    // ========================================
    function automatic bit is_blank(input byte c);
        return c == " " || c == "\t" || c == "\n" || c == "\r";
    endfunction

    // blank lines and # lines carry no fields
    function automatic bit has_fields(input string text);
        for (int k = 0; k < text.len(); k++) begin
            if (text[k] == "#") begin
                return 1'b0;
            end
            if (!is_blank(text[k])) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // 30 columns as listed at the head of the golden file
    function automatic step_t build_step(input logic [31:0] fld [30]);
        step_t st;
        int    b;
        st = '0;
        st.disp_valid = fld[0][DISPATCH_WIDTH-1:0];
        for (int l = 0; l < DISPATCH_WIDTH; l++) begin
            b = 1 + 7 * l;
            st.disp_pkt[l].fu_type    = fu_type_e'(fld[b][1:0]);
            st.disp_pkt[l].imm_kind   = imm_kind_e'(fld[b+1][0]);
            st.disp_pkt[l].inst       = fld[b+2];
            st.disp_pkt[l].rob_idx    = fld[b+3][ROB_W-1:0];
            st.disp_pkt[l].src1_tag   = fld[b+4][TAG_W-1:0];
            st.disp_pkt[l].src2_tag   = fld[b+5][TAG_W-1:0];
            // ready column holds src1 in bit 1 and src2 in bit 0
            st.disp_pkt[l].src1_ready = fld[b+6][1];
            st.disp_pkt[l].src2_ready = fld[b+6][0];
            st.disp_pkt[l].valid      = st.disp_valid[l];
        end
        st.cdb_valid = fld[15][CDB_WIDTH-1:0];
        for (int c = 0; c < CDB_WIDTH; c++) begin
            st.cdb_tag[c] = fld[16+c][TAG_W-1:0];
        end
        st.flush      = fld[18][2];
        st.mispredict = fld[18][1];
        st.correct    = fld[18][0];
        st.free_slots = fld[19][COUNT_W-1:0];
        st.full       = fld[20][0];
        // expected issue per unit type in enum order
        for (int f = 0; f < FU_NUM; f++) begin
            b = 21 + 3 * f;
            st.issue[f].valid   = fld[b][0];
            st.issue[f].fu_type = fu_type_e'(f);
            st.issue[f].rob_idx = fld[b+1][ROB_W-1:0];
            st.issue[f].imm     = fld[b+2];
        end
        return st;
    endfunction

    task automatic load_golden();
        int          fd;
        int          n;
        int          start;
        int          line_no;
        bit          ok;
        string       text;
        string       tok;
        logic [31:0] val;
        logic [31:0] fld [30];
        fd = $fopen("tests/rs_golden.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the golden file tests/rs_golden.txt");
        end
        line_no = 0;
        while (!$feof(fd)) begin
            text = "";
            n = $fgets(text, fd);
            line_no++;
            if (has_fields(text)) begin
                // whitespace separated hex columns
                n     = 0;
                start = -1;
                ok    = 1'b1;
                for (int k = 0; k <= text.len(); k++) begin
                    if (k < text.len() && !is_blank(text[k])) begin
                        if (start < 0) begin
                            start = k;
                        end
                    end else if (start >= 0) begin
                        tok   = text.substr(start, k - 1);
                        start = -1;
                        if ($sscanf(tok, "%h", val) != 1 || n >= 30) begin
                            ok = 1'b0;
                        end else begin
                            fld[n] = val;
                        end
                        n++;
                    end
                end
                if (!ok || n != 30) begin
                    abort_run($sformatf("golden file line %0d is malformed, %0d fields found",
                                        line_no, n));
                end
                steps.push_back(build_step(fld));
            end
        end
        $fclose(fd);
        if (steps.size() == 0) begin
            abort_run("the golden file holds no stimulus lines");
        end
    endtask

    // ========================================
    // drive and compare
    // ========================================
    task automatic apply_step(input step_t st);
        disp_valid    = st.disp_valid;
        disp_pkt      = st.disp_pkt;
        cdb_valid     = st.cdb_valid;
        cdb_tag       = st.cdb_tag;
        flush         = st.flush;
        br_mispredict = st.mispredict;
        br_correct    = st.correct;
    endtask

    task automatic check_count(input int step, input logic [COUNT_W-1:0] got_free,
                               input logic got_full, input logic [COUNT_W-1:0] exp_free,
                               input logic exp_full);
        if (got_free !== exp_free) begin
            abort_run($sformatf("mismatch at %0t: step %0d free_slots_o is %0d, expected %0d",
                                $time, step, got_free, exp_free));
        end
        if (got_full !== exp_full) begin
            abort_run($sformatf("mismatch at %0t: step %0d rs_full_o is %0b, expected %0b",
                                $time, step, got_full, exp_full));
        end
    endtask

    task automatic check_issue(input int step, input issue_pkt_t got, input issue_pkt_t exp);
        string unit;
        unit = exp.fu_type.name();
        if (got.valid !== exp.valid) begin
            abort_run($sformatf("mismatch at %0t: step %0d %s issue valid is %0b, expected %0b",
                                $time, step, unit, got.valid, exp.valid));
        end
        // payload only matters on a valid issue
        if (exp.valid) begin
            if (got.fu_type !== exp.fu_type) begin
                abort_run($sformatf("mismatch at %0t: step %0d %s issue fu_type is %0d",
                                    $time, step, unit, got.fu_type));
            end
            if (got.rob_idx !== exp.rob_idx) begin
                abort_run($sformatf("mismatch at %0t: step %0d %s rob_idx is %0h, expected %0h",
                                    $time, step, unit, got.rob_idx, exp.rob_idx));
            end
            if (got.imm !== exp.imm) begin
                abort_run($sformatf("mismatch at %0t: step %0d %s imm is %08h, expected %08h",
                                    $time, step, unit, got.imm, exp.imm));
            end
        end
    endtask

    // run limit of golden length plus margin
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            abort_run($sformatf("timeout, run did not end within %0d cycles", cycle_limit));
        end
    end

    initial begin
        flush         = 1'b0;
        disp_valid    = '0;
        disp_pkt      = '0;
        cdb_valid     = '0;
        cdb_tag       = '0;
        br_mispredict = 1'b0;
        br_correct    = 1'b0;
        load_golden();
        cycle_limit = steps.size() + 20;
        @(negedge reset);
        foreach (steps[i]) begin
            @(negedge clock);
            apply_step(steps[i]);
            // outputs settle after the rising edge and are sampled 10 ns before the next fall
            @(posedge clock);
            #40;
            check_count(i + 1, free_slots, rs_full, steps[i].free_slots, steps[i].full);
            for (int f = 0; f < FU_NUM; f++) begin
                check_issue(i + 1, issue[f], steps[i].issue[f]);
            end
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- tests/rs_golden.txt
# hex: dv, 2x lane {fu kind inst rob src1 src2 rdy(b1=src1 b0=src2)}, cdb {valid tag0 tag1},
# pulse (b2=flush b1=mispredict b0=correct), free full, then alu/mult/branch {valid rob imm}
0 0 0 00000000 0 00 00 0 0 0 00000000 0 00 00 0 0 00 00 0 2 0 0 0 00000000 0 0 00000000 0 0 00000000
3 0 0 00500093 1 00 00 3 1 0 00000000 2 00 00 3 0 00 00 0 2 0 1 1 00000005 1 2 00000000 0 0 00000000
3 0 0 00000000 6 0c 00 1 2 0 00000000 3 00 00 3 0 00 00 0 2 0 0 0 00000000 0 0 00000000 1 3 00000000
3 0 0 00000000 4 0a 00 1 1 0 00000000 5 00 0b 2 0 00 00 0 2 0 0 0 00000000 0 0 00000000 0 0 00000000
1 0 0 00000000 7 00 00 3 0 0 00000000 0 00 00 0 0 00 00 2 2 0 0 0 00000000 0 0 00000000 0 0 00000000
0 0 0 00000000 0 00 00 0 0 0 00000000 0 00 00 0 3 0a 0c 0 2 0 1 6 00000000 0 0 00000000 0 0 00000000
0 0 0 00000000 0 00 00 0 0 0 00000000 0 00 00 0 1 0b 00 0 2 0 0 0 00000000 0 0 00000000 0 0 00000000
1 1 0 00000000 8 0d 00 1 0 0 00000000 0 00 00 0 1 0d 00 0 2 0 0 0 00000000 1 8 00000000 0 0 00000000
3 2 0 00000000 9 0e 00 1 0 0 00000000 a 0f 00 1 0 00 00 0 2 0 0 0 00000000 0 0 00000000 0 0 00000000
0 0 0 00000000 0 00 00 0 0 0 00000000 0 00 00 0 1 0e 00 0 2 0 0 0 00000000 0 0 00000000 1 9 00000000
0 0 0 00000000 0 00 00 0 0 0 00000000 0 00 00 0 0 00 00 1 2 0 0 0 00000000 0 0 00000000 0 0 00000000
0 0 0 00000000 0 00 00 0 0 0 00000000 0 00 00 0 1 0f 00 0 2 0 1 a 00000000 0 0 00000000 0 0 00000000
3 0 0 ff800013 b 00 00 3 1 1 12345037 c 00 00 3 0 00 00 0 2 0 1 b fffffff8 1 c 12345000 0 0 00000000
3 0 0 00000000 d 00 00 3 0 0 00000000 e 00 00 3 0 00 00 0 2 0 1 d 00000000 0 0 00000000 0 0 00000000
3 1 0 00000000 f 10 00 1 1 0 00000000 0 10 00 1 0 00 00 0 2 0 1 e 00000000 0 0 00000000 0 0 00000000
3 0 0 00000000 1 00 11 2 0 0 00000000 2 00 11 2 0 00 00 0 2 0 0 0 00000000 0 0 00000000 0 0 00000000
3 1 0 00000000 3 12 00 1 1 0 00000000 4 12 00 1 0 00 00 0 2 0 0 0 00000000 0 0 00000000 0 0 00000000
1 0 0 00000000 5 00 13 2 0 0 00000000 0 00 00 0 0 00 00 0 1 0 0 0 00000000 0 0 00000000 0 0 00000000
1 0 0 00000000 6 00 13 2 0 0 00000000 0 00 00 0 0 00 00 0 0 1 0 0 00000000 0 0 00000000 0 0 00000000
0 0 0 00000000 0 00 00 0 0 0 00000000 0 00 00 0 1 10 00 0 0 1 0 0 00000000 1 f 00000000 0 0 00000000
0 0 0 00000000 0 00 00 0 0 0 00000000 0 00 00 0 0 00 00 0 1 0 0 0 00000000 1 0 00000000 0 0 00000000
0 0 0 00000000 0 00 00 0 0 0 00000000 0 00 00 0 0 00 00 4 2 0 0 0 00000000 0 0 00000000 0 0 00000000
0 0 0 00000000 0 00 00 0 0 0 00000000 0 00 00 0 3 11 13 0 2 0 0 0 00000000 0 0 00000000 0 0 00000000
1 0 1 abcde0b7 2 00 00 3 0 0 00000000 0 00 00 0 0 00 00 0 2 0 1 2 abcde000 0 0 00000000 0 0 00000000

//--- files.f
src/rs_pkg.sv
src/rs_entry.sv
src/dispatch_select.sv
src/reservation_station.sv
src/issue_select.sv
src/rs_cluster.sv
tests/tb_clock.sv
tests/rs_assert.sv
tests/rs_tb.sv

//--- Bender.yml
package:
  name: rs_cluster

sources:
  - files:
      - src/rs_pkg.sv
      - src/rs_entry.sv
      - src/dispatch_select.sv
      - src/reservation_station.sv
      - src/issue_select.sv
      - src/rs_cluster.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/rs_assert.sv
      - tests/rs_tb.sv
